// ==== functionGen.f ====
verilog/funcGenCfgPkg.sv
verilog/funcGenSamplePkg.sv
verilog/sampleCreditCtrl.sv
verilog/phaseAccumulator.sv
verilog/sineTriangleShaper.sv
verilog/squareSawShaper.sv
verilog/outputScaler.sv
verilog/functionGen.sv
verif/functionGenTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the function generator testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -j 0 --top-module functionGenTb -f functionGen.f -Mdir obj_dir \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/VfunctionGenTb > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -qx "STATUS: PASS" sim.log && echo "Run succeeded" && exit 0 \
  || { echo "Run did not succeed"; exit 1; }

// ==== verif/functionGenTb.sv ====
// Testbench for the DDS function generator
// Plays stimulus records, returns credits at random and checks each sample
`timescale 1ns/1ns
`default_nettype none

module functionGenTb;

  localparam int FREQ_WIDTH = 16;
  localparam int OUT_WIDTH  = 16;
  localparam int CREDITS    = 4;
  localparam int LATENCY    = 4;    // Issue to sampleValid
  localparam int STIM_DEPTH = 256;
  localparam int HOLD_WAIT  = 16;   // Cycles watched while credits are withheld

  logic                                clk;
  logic                                rst;
  logic                                run;
  funcGenCfgPkg::waveType_e            waveType;
  logic [FREQ_WIDTH-1:0]               freq;
  logic [FREQ_WIDTH-1:0]               phaseOffset;
  logic [funcGenCfgPkg::AMP_WIDTH-1:0] amplitude;
  logic signed [OUT_WIDTH-1:0]         offset;
  logic                                creditReturn;
  logic signed [OUT_WIDTH-1:0]         sample;
  logic                                sampleValid;

  logic [31:0] stim [0:STIM_DEPTH-1];
  int          seed;
  int          cycle;
  int          cycleLimit;
  int          rxTotal;         // Samples received since reset
  int          returnedTotal;   // Credits handed back since reset
  int          recStart;        // rxTotal when the current record began
  int          expBase;
  int          expCount;
  logic        holdCredits;
  int          issueCycles[$];  // Cycle of each issue still in flight

  functionGen functionGen_i (
    .clk          (clk),
    .rst          (rst),
    .run          (run),
    .waveType     (waveType),
    .freq         (freq),
    .phaseOffset  (phaseOffset),
    .amplitude    (amplitude),
    .offset       (offset),
    .creditReturn (creditReturn),
    .sample       (sample),
    .sampleValid  (sampleValid)
  );

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      abortRun($sformatf("Mismatch on %s", name));
    end
  endtask

  // Returns on a rising edge once n samples of this record are in
  task automatic waitSamples(input int n);
    while (rxTotal - recStart < n) @(posedge clk);
  endtask

  task automatic playRecord(input int p);
    @(posedge clk);
    waveType    <= funcGenCfgPkg::waveType_e'(stim[p][1:0]);
    freq        <= stim[p+1][FREQ_WIDTH-1:0];
    phaseOffset <= stim[p+2][FREQ_WIDTH-1:0];
    amplitude   <= stim[p+3][funcGenCfgPkg::AMP_WIDTH-1:0];
    offset      <= stim[p+4][OUT_WIDTH-1:0];
    holdCredits <= stim[p+5][0];
    recStart = rxTotal;
    expBase  = p + 7;
    expCount = int'(stim[p+6]);
    @(posedge clk);
    run <= 1'b1;
    if (stim[p+5][0]) begin
      waitSamples(CREDITS);   // Initial credits only
      repeat (HOLD_WAIT) @(posedge clk);
      checkValue("sampleValid count", rxTotal - recStart, 32'(CREDITS));
      holdCredits <= 1'b0;
    end
    waitSamples(expCount);
    run <= 1'b0;
    // Drain the pipeline and settle all credits before the next record
    while (issueCycles.size() != 0 || returnedTotal != rxTotal || creditReturn) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycle = 0;
    forever begin
      @(posedge clk);
      cycle++;
      if (cycleLimit > 0 && cycle > cycleLimit) begin
        abortRun("Timeout: the expected samples did not arrive within the cycle limit");
      end
    end
  end

  // Consumer side, one credit back per received sample after a random delay
  initial begin
    creditReturn  = 1'b0;
    returnedTotal = 0;
    forever begin
      @(posedge clk);
      if (!rst && !holdCredits && returnedTotal < rxTotal && ($random(seed) & 1) == 1) begin
        creditReturn  <= 1'b1;
        returnedTotal <= returnedTotal + 1;
      end else begin
        creditReturn <= 1'b0;
      end
    end
  end

  // Outputs sampled on the falling edge, away from the driving edge
  initial begin
    rxTotal = 0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (functionGen_i.issue) issueCycles.push_back(cycle);
        if (sampleValid) begin
          if (issueCycles.size() == 0) abortRun("A sample arrived without a matching issue");
          checkValue("sampleValid latency", cycle - issueCycles.pop_front(), 32'(LATENCY));
          if (rxTotal - recStart < expCount) begin
            checkValue("sample", 32'($unsigned(sample)), stim[expBase + rxTotal - recStart]);
          end
          rxTotal++;
        end
      end
    end
  end

  initial begin : mainSeq
    int p;
    int total;
    seed        = 5753;
    rst         = 1'b1;
    run         = 1'b0;
    waveType    = funcGenCfgPkg::SINE;
    freq        = '0;
    phaseOffset = '0;
    amplitude   = '0;
    offset      = '0;
    holdCredits = 1'b0;
    recStart    = 0;
    expBase     = 0;
    expCount    = 0;
    cycleLimit  = 0;
    $readmemh("verif/functionGen_stimulus.txt", stim);
    total = 0;
    p     = 0;
    while (p < STIM_DEPTH && stim[p] !== 32'hff) begin
      total += int'(stim[p+6]);
      p     += 7 + int'(stim[p+6]);
    end
    cycleLimit = 20 * total + 200;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    repeat (8) begin   // Run still low
      @(negedge clk);
      checkValue("sampleValid", 32'(sampleValid), 32'h0);
    end
    p = 0;
    while (stim[p] !== 32'hff) begin
      playRecord(p);
      p += 7 + int'(stim[p+6]);
    end
    repeat (4) @(posedge clk);
    if (issueCycles.size() == 0 && returnedTotal == rxTotal) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abortRun("Samples or credits were still outstanding at the end of the run");
    end
  end

endmodule

`default_nettype wire

// ==== verif/functionGen_stimulus.txt ====
// Record: wave freq phaseOffset amplitude offset creditMode count, then count expected samples
// All hex; wave 0 sine 1 triangle 2 square 3 sawtooth; creditMode 1 withholds credits first
// Square with phase offset and accumulator wraparound
2 2000 1000 8000 0000 0 a
3fff 3fff 3fff 3fff c000 c000 c000 c000
3fff 3fff
// Sawtooth across the signed wrap
3 3000 0800 8000 0000 0 8
0400 1c00 3400 cc00 e400 fc00 1400 2c00
// Triangle through all four quadrants
1 1800 0100 8000 0000 0 c
0100 1900 3100 36ff 1eff 06ff eeff d6ff
c100 d900 f100 0900
// Sine at the quadrant edges, table ends 0 and 1023
0 4000 0000 8000 0000 0 8
000c 3fff fff3 c000 000c 3fff fff3 c000
// Sine near the octant points, table entries 511 and 512
0 4000 1ff0 8000 0000 0 4
2d38 2d4a d2c7 d2b6
// Large positive offset saturates the top
2 4000 0000 8000 7000 0 4
7fff 7fff 3000 3000
// Large negative offset saturates the bottom
2 4000 0000 8000 9000 0 4
cfff cfff 8000 8000
// Small amplitude and offset pass through unclamped
2 4000 0000 0010 0005 0 4
000c 000c fffd fffd
// Credits withheld, then returned at random
3 1000 0000 8000 0000 1 a
0000 0800 1000 1800 2000 2800 3000 3800
c000 c800
// Same configuration again, restarts at sample zero
3 1000 0000 8000 0000 0 6
0000 0800 1000 1800 2000 2800
// End marker
ff

// ==== verilog/funcGenCfgPkg.sv ====
// Internal width constants of the generator
// Wave type opcodes and credit control states
`default_nettype none

package funcGenCfgPkg;

  // Signed unscaled sample, one word wide
  localparam int LOCAL_WIDTH = 18;

  // Quarter-wave table
  localparam int ANGLE_WIDTH = 10;   // Address bits
  localparam int SINE_WIDTH  = 18;   // Entry width

  localparam int AMP_WIDTH = 16;     // Unsigned amplitude

  // Wave opcode, bit 0 separates the two waves of each shaper
  typedef enum logic [1:0] {
    SINE     = 2'd0,
    TRIANGLE = 2'd1,
    SQUARE   = 2'd2,
    SAWTOOTH = 2'd3
  } waveType_e;

  // Credit control FSM
  typedef enum logic {
    IDLE = 1'b0,   // Run low, accumulator held at zero
    RUN  = 1'b1    // Issuing while credits last
  } creditState_e;

endpackage

`default_nettype wire

// ==== verilog/funcGenSamplePkg.sv ====
// Structs for the sample path
// Pipeline tag and shaped sample
`default_nettype none

package funcGenSamplePkg;

  // Travels next to the phase and shaper stages
  typedef struct packed {
    logic                     valid;
    funcGenCfgPkg::waveType_e waveType;
  } sampleTag_t;

  // One per shaper, valid only for the waves that shaper owns
  typedef struct packed {
    logic                                         valid;
    logic signed [funcGenCfgPkg::LOCAL_WIDTH-1:0] value;   // Unscaled, full scale 131071
  } shapedSample_t;

endpackage

`default_nettype wire

// ==== verilog/functionGen.sv ====
// DDS function generator top level
// Credit control, phase accumulator, two shapers and output scaler
`timescale 1ns/1ns
`default_nettype none

module functionGen #(
  parameter int FREQ_WIDTH = 16,
  parameter int OUT_WIDTH  = 16,
  parameter int CREDITS    = 4
) (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  run,
  input  wire  funcGenCfgPkg::waveType_e       waveType,
  input  wire  [FREQ_WIDTH-1:0]                freq,
  input  wire  [FREQ_WIDTH-1:0]                phaseOffset,
  input  wire  [funcGenCfgPkg::AMP_WIDTH-1:0]  amplitude,
  input  wire  signed [OUT_WIDTH-1:0]          offset,
  input  wire                                  creditReturn,
  output logic signed [OUT_WIDTH-1:0]          sample,
  output logic                                 sampleValid
);

  logic                            issue;
  logic [FREQ_WIDTH-1:0]           phase;
  funcGenSamplePkg::sampleTag_t    accTag;
  funcGenSamplePkg::sampleTag_t    scalerTag;     // Delayed one stage by the square/saw shaper
  funcGenSamplePkg::shapedSample_t sineTriShaped;
  funcGenSamplePkg::shapedSample_t squareSawShaped;

  sampleCreditCtrl #(.CREDITS(CREDITS)) creditCtrl_i (
    .clk          (clk),
    .rst          (rst),
    .run          (run),
    .creditReturn (creditReturn),
    .issue        (issue)
  );

  phaseAccumulator #(.FREQ_WIDTH(FREQ_WIDTH)) phaseAcc_i (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .issue       (issue),
    .freq        (freq),
    .phaseOffset (phaseOffset),
    .waveType    (waveType),
    .phase       (phase),
    .tag         (accTag)
  );

  sineTriangleShaper #(.FREQ_WIDTH(FREQ_WIDTH)) sineTri_i (
    .clk    (clk),
    .rst    (rst),
    .phase  (phase),
    .tag    (accTag),
    .shaped (sineTriShaped)
  );

  squareSawShaper #(.FREQ_WIDTH(FREQ_WIDTH)) squareSaw_i (
    .clk    (clk),
    .rst    (rst),
    .phase  (phase),
    .tag    (accTag),
    .shaped (squareSawShaped),
    .tagOut (scalerTag)
  );

  outputScaler #(.OUT_WIDTH(OUT_WIDTH)) scaler_i (
    .clk         (clk),
    .rst         (rst),
    .sineTri     (sineTriShaped),
    .squareSaw   (squareSawShaped),
    .tag         (scalerTag),
    .amplitude   (amplitude),
    .offset      (offset),
    .sample      (sample),
    .sampleValid (sampleValid)
  );

endmodule

`default_nettype wire

// ==== verilog/outputScaler.sv ====
// Wave selection, amplitude multiply, offset add
// Saturation to the output width
`timescale 1ns/1ns
`default_nettype none

module outputScaler #(
  parameter int OUT_WIDTH = 16
) (
  input  wire                                         clk,
  input  wire                                         rst,
  input  wire  funcGenSamplePkg::shapedSample_t       sineTri,
  input  wire  funcGenSamplePkg::shapedSample_t       squareSaw,
  input  wire  funcGenSamplePkg::sampleTag_t          tag,
  input  wire  [funcGenCfgPkg::AMP_WIDTH-1:0]         amplitude,
  input  wire  signed [OUT_WIDTH-1:0]                 offset,
  output logic signed [OUT_WIDTH-1:0]                 sample,
  output logic                                        sampleValid
);

  localparam int LW  = funcGenCfgPkg::LOCAL_WIDTH;
  localparam int PW  = LW + funcGenCfgPkg::AMP_WIDTH + 1;   // Product width
  localparam int WW  = ((PW > OUT_WIDTH + LW) ? PW : OUT_WIDTH + LW) + 1;
  localparam int SHW = WW - LW;

  localparam logic signed [OUT_WIDTH-1:0] MAX_OUT = {1'b0, {(OUT_WIDTH - 1){1'b1}}};
  localparam logic signed [OUT_WIDTH-1:0] MIN_OUT = {1'b1, {(OUT_WIDTH - 1){1'b0}}};

  logic signed [LW-1:0]        unscaled;
  logic signed [WW-1:0]        wideNext;
  logic signed [WW-1:0]        wide;
  logic                        wideValid;
  logic [SHW-1:0]              shifted;
  logic                        fits;
  logic signed [OUT_WIDTH-1:0] clamped;

  assign unscaled = (tag.waveType == funcGenCfgPkg::SINE ||
                     tag.waveType == funcGenCfgPkg::TRIANGLE) ? sineTri.value : squareSaw.value;

  // Offset lines up with the integer part of the product
  assign wideNext = unscaled * $signed({1'b0, amplitude}) + (WW'(offset) <<< LW);

  always_ff @(posedge clk) begin
    if (rst) begin
      wideValid <= 1'b0;
    end else begin
      wideValid <= tag.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (tag.valid) begin
      wide <= wideNext;
    end
  end

  assign shifted = wide[WW-1:LW];   // Arithmetic shift right by 18
  // In range when all bits above the output sign match it
  assign fits    = (&shifted[SHW-1:OUT_WIDTH-1]) || !(|shifted[SHW-1:OUT_WIDTH-1]);
  assign clamped = fits ? shifted[OUT_WIDTH-1:0] : (shifted[SHW-1] ? MIN_OUT : MAX_OUT);

  always_ff @(posedge clk) begin
    if (rst) begin
      sampleValid <= 1'b0;
    end else begin
      sampleValid <= wideValid;
    end
  end

  always_ff @(posedge clk) begin
    if (wideValid) begin
      sample <= clamped;
    end
  end

  // Exactly one shaper owns each tagged sample
  assert property (@(posedge clk) disable iff (rst)
    tag.valid ? $onehot({sineTri.valid, squareSaw.valid}) : !(sineTri.valid || squareSaw.valid));

  // Limits only when the integer part of the wide word leaves the output range
  assert property (@(posedge clk) disable iff (rst)
    wideValid |=> ((($past(wide) >>> LW) > WW'(MAX_OUT)) ? (sample == MAX_OUT) :
                   (($past(wide) >>> LW) < WW'(MIN_OUT)) ? (sample == MIN_OUT) :
                   (sample == $past(wide[LW +: OUT_WIDTH]))));

endmodule

`default_nettype wire

// ==== verilog/phaseAccumulator.sv ====
// Phase accumulator with phase offset and per-sample tag
`timescale 1ns/1ns
`default_nettype none

module phaseAccumulator #(
  parameter int FREQ_WIDTH = 16
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           run,
  input  wire                           issue,
  input  wire  [FREQ_WIDTH-1:0]         freq,
  input  wire  [FREQ_WIDTH-1:0]         phaseOffset,
  input  wire  funcGenCfgPkg::waveType_e waveType,
  output logic [FREQ_WIDTH-1:0]         phase,
  output funcGenSamplePkg::sampleTag_t  tag
);

  logic [FREQ_WIDTH-1:0]    acc;
  logic                     tagValid;
  funcGenCfgPkg::waveType_e tagWave;

  // Cleared while run is low so the next run restarts at sample zero
  always_ff @(posedge clk) begin
    if (rst || !run) begin
      acc <= '0;
    end else if (issue) begin
      acc <= acc + freq;   // Wraps modulo 2^FREQ_WIDTH
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tagValid <= 1'b0;
    end else begin
      tagValid <= issue;
    end
  end

  // Configuration sampled at issue
  always_ff @(posedge clk) begin
    if (issue) begin
      phase   <= acc + phaseOffset;
      tagWave <= waveType;
    end
  end

  assign tag = '{valid: tagValid, waveType: tagWave};

endmodule

`default_nettype wire

// ==== verilog/sampleCreditCtrl.sv ====
// Credit counter and issue decision for the sample pipeline
`timescale 1ns/1ns
`default_nettype none

module sampleCreditCtrl #(
  parameter int CREDITS = 4
) (
  input  wire  clk,
  input  wire  rst,
  input  wire  run,
  input  wire  creditReturn,
  output logic issue
);

  localparam int CW = $clog2(CREDITS + 2);

  funcGenCfgPkg::creditState_e state;
  logic [CW-1:0]               count;
  logic [CW-1:0]               avail;

  // A return in this cycle is already spendable
  assign avail = count + CW'(creditReturn);

  // Issue needs the armed state and at least one credit
  assign issue = run && (state == funcGenCfgPkg::RUN) && (avail != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= funcGenCfgPkg::IDLE;
    end else begin
      case (state)
        funcGenCfgPkg::IDLE: if (run) state <= funcGenCfgPkg::RUN;
        funcGenCfgPkg::RUN:  if (!run) state <= funcGenCfgPkg::IDLE;
        default:             state <= funcGenCfgPkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= CW'(CREDITS);
    end else begin
      count <= avail - CW'(issue);   // Spend one per issued sample
    end
  end

  // Consumer must never return more than it was given
  // An underflow wraps above CREDITS as well
  assert property (@(posedge clk) disable iff (rst)
    count <= CW'(CREDITS));

endmodule

`default_nettype wire

// ==== verilog/sineTriangleShaper.sv ====
// Sine from a quarter-wave table and triangle from the folded phase
// Sign of both rebuilt from the phase top bit
`timescale 1ns/1ns
`default_nettype none

module sineTriangleShaper #(
  parameter int FREQ_WIDTH = 16
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire  [FREQ_WIDTH-1:0]         phase,
  input  wire  funcGenSamplePkg::sampleTag_t tag,
  output funcGenSamplePkg::shapedSample_t   shaped
);

  localparam int  LW    = funcGenCfgPkg::LOCAL_WIDTH;
  localparam int  AW    = funcGenCfgPkg::ANGLE_WIDTH;
  localparam int  SW    = funcGenCfgPkg::SINE_WIDTH;
  localparam int  DEPTH = 1 << AW;
  localparam real PI    = 3.141592653589793;
  localparam real PEAK  = real'((1 << (LW - 1)) - 1);   // 131071

  logic [SW-1:0]            sineTable [DEPTH];
  logic                     signBit;
  logic [FREQ_WIDTH-3:0]    xorPhase;
  logic [FREQ_WIDTH+AW-3:0] xorExt;
  logic [AW-1:0]            tableAddr;
  logic [FREQ_WIDTH-2:0]    triRaw;
  logic [LW-2:0]            triangle;
  logic [LW-2:0]            halfWave;
  logic [LW-1:0]            value;
  logic                     isMine;
  logic                     shapedValid;
  logic signed [LW-1:0]     shapedValue;

  // Half-step offset keeps the table symmetric around the fold
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      sineTable[i] = SW'($rtoi(PEAK * $sin((real'(i) + 0.5) * PI / (2.0 * DEPTH)) + 0.5));
    end
  end

  assign signBit  = phase[FREQ_WIDTH-1];
  // Quadrants 1 and 3 read the table backwards
  assign xorPhase = phase[FREQ_WIDTH-3:0] ^ {(FREQ_WIDTH - 2){phase[FREQ_WIDTH-2]}};

  // Zero pad covers phases narrower than the table address
  assign xorExt    = {xorPhase, {AW{1'b0}}};
  assign tableAddr = xorExt[FREQ_WIDTH+AW-3 -: AW];

  assign triRaw = {xorPhase, 1'b1};   // Centre of the phase step

  generate
    if (FREQ_WIDTH > LW) begin : gTriNarrow
      assign triangle = (LW - 1)'(triRaw >> (FREQ_WIDTH - LW));
    end else begin : gTriWiden
      assign triangle = (LW - 1)'(triRaw) << (LW - FREQ_WIDTH);
    end
  endgenerate

  assign halfWave = (tag.waveType == funcGenCfgPkg::TRIANGLE) ? triangle
                                                              : (LW - 1)'(sineTable[tableAddr]);

  // Ones complement plus one on the negative half
  assign value = ({LW{signBit}} ^ {1'b0, halfWave}) + LW'(signBit);

  assign isMine = (tag.waveType == funcGenCfgPkg::SINE) ||
                  (tag.waveType == funcGenCfgPkg::TRIANGLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      shapedValid <= 1'b0;
    end else begin
      shapedValid <= tag.valid && isMine;
    end
  end

  always_ff @(posedge clk) begin
    if (tag.valid) begin
      shapedValue <= value;
    end
  end

  assign shaped = '{valid: shapedValid, value: shapedValue};

endmodule

`default_nettype wire

// ==== verilog/squareSawShaper.sv ====
// Square and sawtooth straight from the phase bits
// Also carries the tag on to the scaler
`timescale 1ns/1ns
`default_nettype none

module squareSawShaper #(
  parameter int FREQ_WIDTH = 16
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire  [FREQ_WIDTH-1:0]         phase,
  input  wire  funcGenSamplePkg::sampleTag_t tag,
  output funcGenSamplePkg::shapedSample_t   shaped,
  output funcGenSamplePkg::sampleTag_t      tagOut
);

  localparam int LW = funcGenCfgPkg::LOCAL_WIDTH;

  logic                     signBit;
  logic signed [LW-1:0]     square;
  logic signed [LW-1:0]     saw;
  logic                     isMine;
  logic                     shapedValid;
  logic signed [LW-1:0]     shapedValue;
  logic                     tagValid;
  funcGenCfgPkg::waveType_e tagWave;

  assign signBit = phase[FREQ_WIDTH-1];
  assign square  = {signBit, {(LW - 2){~signBit}}, 1'b1};   // +/-131071

  generate
    if (FREQ_WIDTH >= LW) begin : gSawNarrow
      assign saw = LW'($signed(phase) >>> (FREQ_WIDTH - LW));
    end else begin : gSawWiden
      assign saw = LW'($signed(phase)) <<< (LW - FREQ_WIDTH);
    end
  endgenerate

  assign isMine = (tag.waveType == funcGenCfgPkg::SQUARE) ||
                  (tag.waveType == funcGenCfgPkg::SAWTOOTH);

  always_ff @(posedge clk) begin
    if (rst) begin
      shapedValid <= 1'b0;
      tagValid    <= 1'b0;
    end else begin
      shapedValid <= tag.valid && isMine;
      tagValid    <= tag.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (tag.valid) begin
      shapedValue <= (tag.waveType == funcGenCfgPkg::SQUARE) ? square : saw;
      tagWave     <= tag.waveType;
    end
  end

  assign shaped = '{valid: shapedValid, value: shapedValue};
  assign tagOut = '{valid: tagValid, waveType: tagWave};

endmodule

`default_nettype wire
